//--- hw/erx_clocks_pkg.sv
package erx_clocks_pkg;

   //####################
   // Sequencer states
   //####################

   // Receiver bring-up steps, advanced on heartbeat only
   typedef enum logic [1:0]
   {
      RX_RESET_ALL = 2'b00,   // Generator and core held in reset
      RX_START_PLL = 2'b01,   // Generator running, waiting on lock
      RX_ACTIVE    = 2'b10    // Locked, core resets released
   } erx_reset_state_t;

   //####################
   // Parameter defaults
   //####################

   // Heartbeat counter width
   // Heartbeat period is 2**RCW sys_clk cycles
   localparam int RCW_DEFAULT = 8;

   // rx_lclk edges from generator reset release to lock
   localparam int LOCK_CYCLES_DEFAULT = 16;

   // Reset synchronizer depth, two flops minimum
   localparam int SYNC_STAGES_DEFAULT = 2;

   // Bring-up latency from rx_nreset_in release to rx_active is
   // at most three heartbeat periods plus lock time
   // plus two sys_clk cycles for the lock synchronizer
   // Stepping the FSM on a slow pulse gives the generator
   // plenty of time to settle between steps

endpackage

//--- hw/erx_pll_if.sv
`timescale 1ns/10ps

// Receive clock generator bundle
interface erx_pll_if;

   logic pll_reset;      // Generator reset, active high
   logic pll_locked;     // Lock level, rx_lclk domain
   logic rx_lclk;        // High speed IO clock
   logic rx_lclk_div4;   // Core clock, rx_lclk / 4

   // Generator side
   modport gen
   (
      input  pll_reset,
      output pll_locked,
      output rx_lclk,
      output rx_lclk_div4
   );

   // Sequencer side, lock is crossed into sys_clk there
   modport seq
   (
      output pll_reset,
      input  pll_locked
   );

   // Reset synchronizers only look at the clocks
   modport sync
   (
      input rx_lclk,
      input rx_lclk_div4
   );

endinterface

//--- hw/erx_heartbeat.sv
`timescale 1ns/10ps

// Slow tick for the reset sequencer
module erx_heartbeat
   import erx_clocks_pkg::*;
#(
   parameter int RCW = RCW_DEFAULT    // Period is 2**RCW cycles
)
(
   input  logic sys_clk,
   input  logic rx_nreset_in,
   output logic heartbeat             // One cycle high per wrap
);

   logic [RCW-1:0] beat_cnt;          // Free-running, wraps on its own

   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         beat_cnt  <= '0;
         heartbeat <= 1'b0;
      end
      else
      begin
         beat_cnt  <= beat_cnt + 1'b1;
         // Registered zero detect
         // One pulse per wrap, no glitches on the output
         heartbeat <= (beat_cnt == '0);
      end
   end

endmodule

//--- hw/erx_clk_gen.sv
`timescale 1ns/10ps

// Behavioral stand-in for the receive PLL and its clock buffers
module erx_clk_gen
   import erx_clocks_pkg::*;
#(
   parameter int LOCK_CYCLES = LOCK_CYCLES_DEFAULT   // Edges until lock
)
(
   input  logic rx_clkin,   // Free-running link clock
   erx_pll_if.gen pll
);

   // Wide enough to hold LOCK_CYCLES itself
   localparam int LCW = $clog2(LOCK_CYCLES + 1);

   logic [1:0]     div_cnt;      // Divide-by-4 counter
   logic [LCW-1:0] lock_cnt;     // Saturates one short of LOCK_CYCLES
   logic           locked_q;     // Lock flag

   //####################
   // High speed clock
   //####################

   // 1:1 output, no multiply or phase shift modeled
   assign pll.rx_lclk = rx_clkin;

   //####################
   // Core clock divider
   //####################

   // 00,01,10,11 -> MSB toggles every 2 edges
   always_ff @(posedge pll.rx_lclk or posedge pll.pll_reset)
   begin
      if (pll.pll_reset)
         div_cnt <= 2'b00;
      else
         div_cnt <= div_cnt + 2'b01;
   end

   assign pll.rx_lclk_div4 = div_cnt[1];   // Straight from a flop

   //####################
   // Lock model
   //####################

   always_ff @(posedge pll.rx_lclk or posedge pll.pll_reset)
   begin
      if (pll.pll_reset)
      begin
         lock_cnt <= '0;
         locked_q <= 1'b0;
      end
      else if (lock_cnt == LCW'(LOCK_CYCLES - 1))
         locked_q <= 1'b1;              // LOCK_CYCLES-th edge, stays set
      else
         lock_cnt <= lock_cnt + 1'b1;  // Still settling
   end

   // Lock level, crossed over by the sequencer
   assign pll.pll_locked = locked_q;

endmodule

//--- hw/erx_reset_seq.sv
`timescale 1ns/10ps

// Receiver reset sequencer, sys_clk domain
module erx_reset_seq
   import erx_clocks_pkg::*;
(
   input  logic sys_clk,
   input  logic rx_nreset_in,   // Async, active low
   input  logic soft_reset,     // Software hold, level
   input  logic heartbeat,      // Step enable
   erx_pll_if.seq pll,
   output logic rx_active       // High only in RX_ACTIVE
);

   logic             lock_meta;   // First sync stage
   logic             lock_sync;   // Lock in sys_clk domain
   erx_reset_state_t state_q;     // Current step
   erx_reset_state_t state_d;     // Next step

   //####################
   // Lock crossing
   //####################

   // Lock is a slow level, two flops are enough
   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
      begin
         lock_meta <= 1'b0;
         lock_sync <= 1'b0;
      end
      else
      begin
         lock_meta <= pll.pll_locked;
         lock_sync <= lock_meta;
      end
   end

   //####################
   // Sequencing FSM
   //####################

   always_comb
   begin
      state_d = state_q;                  // Hold by default
      case (state_q)
         RX_RESET_ALL:
            if (!soft_reset)
               state_d = RX_START_PLL;    // Let the generator run
         RX_START_PLL:
            if (lock_sync)
               state_d = RX_ACTIVE;       // Clocks are stable
         RX_ACTIVE:
            if (soft_reset)
               state_d = RX_RESET_ALL;    // Back to full reset
         default:
            state_d = RX_RESET_ALL;       // Unused code, recover
      endcase
   end

   // Only steps when the heartbeat fires
   always_ff @(posedge sys_clk or negedge rx_nreset_in)
   begin
      if (!rx_nreset_in)
         state_q <= RX_RESET_ALL;
      else if (heartbeat)
         state_q <= state_d;
   end

   //####################
   // Decoded outputs
   //####################

   // Both from the state register, so they change on the same edge
   assign pll.pll_reset = (state_q == RX_RESET_ALL);
   assign rx_active     = (state_q == RX_ACTIVE);

endmodule

//--- hw/erx_rsync.sv
`timescale 1ns/10ps

// Active low reset synchronizer
// Asserts immediately, releases on clk
module erx_rsync
   import erx_clocks_pkg::*;
#(
   parameter int SYNC_STAGES = SYNC_STAGES_DEFAULT   // Two or more
)
(
   input  logic clk,        // Destination clock
   input  logic nrst_in,    // Async release level
   output logic nrst_out    // Synchronized reset, active low
);

   logic [SYNC_STAGES-1:0] sync_q;   // Shift chain, LSB first

   always_ff @(posedge clk or negedge nrst_in)
   begin
      if (!nrst_in)
         sync_q <= '0;                                    // Assert now
      else
         sync_q <= {sync_q[SYNC_STAGES-2:0], 1'b1};       // Fill with ones
   end

   // Release after SYNC_STAGES clk edges
   assign nrst_out = sync_q[SYNC_STAGES-1];

endmodule

//--- hw/erx_clocks.sv
`timescale 1ns/10ps

// Receiver clock and reset block
// Sequencer state is erx_reset_state_t:
//   RX_RESET_ALL  generator in reset, both outputs low
//   RX_START_PLL  generator running, waiting on lock
//   RX_ACTIVE     rx_active high, resets released per domain
module erx_clocks
   import erx_clocks_pkg::*;
#(
   parameter int RCW         = RCW_DEFAULT,           // Heartbeat width
   parameter int LOCK_CYCLES = LOCK_CYCLES_DEFAULT,   // Generator lock time
   parameter int SYNC_STAGES = SYNC_STAGES_DEFAULT    // Sync depth
)
(
   input  logic sys_clk,         // Always-on system clock
   input  logic rx_nreset_in,    // Async system reset, active low
   input  logic soft_reset,      // Software hold of the receiver
   input  logic rx_clkin,        // Receive clock from the link
   output logic rx_lclk,         // High speed IO clock
   output logic rx_lclk_div4,    // Core logic clock
   output logic rx_active,       // Receiver up
   output logic erx_nreset,      // Core reset, rx_lclk_div4 domain
   output logic erx_io_nreset    // IO reset, rx_lclk domain
);

   logic heartbeat;   // Sequencer step pulse
   logic rx_nreset;   // Release level for both domains

   erx_pll_if pll_if ();

   //####################
   // Sequencing
   //####################

   erx_heartbeat #(.RCW(RCW)) u_heartbeat
   (
      .sys_clk      (sys_clk),
      .rx_nreset_in (rx_nreset_in),
      .heartbeat    (heartbeat)
   );

   erx_reset_seq u_reset_seq
   (
      .sys_clk      (sys_clk),
      .rx_nreset_in (rx_nreset_in),
      .soft_reset   (soft_reset),
      .heartbeat    (heartbeat),
      .pll          (pll_if),
      .rx_active    (rx_active)
   );

   //####################
   // Clock generation
   //####################

   erx_clk_gen #(.LOCK_CYCLES(LOCK_CYCLES)) u_clk_gen
   (
      .rx_clkin (rx_clkin),
      .pll      (pll_if)
   );

   assign rx_lclk      = pll_if.rx_lclk;
   assign rx_lclk_div4 = pll_if.rx_lclk_div4;

   //####################
   // Reset syncing
   //####################

   assign rx_nreset = rx_active;   // Receiver out of reset only when active

   erx_rsync #(.SYNC_STAGES(SYNC_STAGES)) rsync_io
   (
      .clk      (pll_if.rx_lclk),
      .nrst_in  (rx_nreset),
      .nrst_out (erx_io_nreset)
   );

   erx_rsync #(.SYNC_STAGES(SYNC_STAGES)) rsync_core
   (
      .clk      (pll_if.rx_lclk_div4),
      .nrst_in  (rx_nreset),
      .nrst_out (erx_nreset)
   );

endmodule

//--- test/erx_clocks_tb.sv
`timescale 1ns/10ps

// Clock and reset block testbench
module erx_clocks_tb
   import erx_clocks_pkg::*;
();

   localparam int RCW         = 4;                    // Short heartbeat for simulation
   localparam int SYS_PERIOD  = 40;                   // ns
   localparam int RX_PERIOD   = 10;                   // ns
   localparam int HB_CYCLES   = 1 << RCW;             // Heartbeat period in sys_clk cycles
   localparam int SYNC_STAGES = SYNC_STAGES_DEFAULT;

   // Lock time rounded up to whole sys_clk cycles
   localparam int LOCK_SYS = (LOCK_CYCLES_DEFAULT * RX_PERIOD + SYS_PERIOD - 1) / SYS_PERIOD;

   // Three heartbeats, lock, two sync flops and one cycle of sampling slack
   localparam int UP_CYCLES   = 3 * HB_CYCLES + LOCK_SYS + 2 + 1;
   localparam int DROP_CYCLES = HB_CYCLES + 1;       // rx_active fall after soft_reset
   // SYNC_STAGES+1 core clock periods rounded up plus one spare
   localparam int SYNC_CYCLES =
      ((SYNC_STAGES + 1) * 4 * RX_PERIOD + SYS_PERIOD - 1) / SYS_PERIOD + 1;

   logic sys_clk;
   logic rx_nreset_in;
   logic soft_reset;
   logic rx_clkin;
   logic rx_lclk;
   logic rx_lclk_div4;
   logic rx_active;
   logic erx_nreset;
   logic erx_io_nreset;

   int     errors    = 0;
   int     timeouts  = 0;
   integer seed;
   bit     checks_on = 1'b0;   // Set once reset is applied

   int lclk_edges = 0;         // Running edge counts per domain
   int div4_edges = 0;
   int lclk_at_rise;           // Snapshot at rx_active rise
   int div4_at_rise;
   int io_release_edges;       // Edges from rx_active rise to release
   int core_release_edges;

   erx_clocks #(.RCW(RCW)) u_dut
   (
      .sys_clk       (sys_clk),
      .rx_nreset_in  (rx_nreset_in),
      .soft_reset    (soft_reset),
      .rx_clkin      (rx_clkin),
      .rx_lclk       (rx_lclk),
      .rx_lclk_div4  (rx_lclk_div4),
      .rx_active     (rx_active),
      .erx_nreset    (erx_nreset),
      .erx_io_nreset (erx_io_nreset)
   );

   //####################
   // Clocks
   //####################

   initial
   begin
      sys_clk = 1'b1;   // First falling edge at 20 ns
      forever #(SYS_PERIOD / 2) sys_clk = ~sys_clk;
   end

   initial
   begin
      rx_clkin = 1'b0;   // Edges never line up with sys_clk rising
      forever #(RX_PERIOD / 2) rx_clkin = ~rx_clkin;
   end

   //####################
   // Reporting
   //####################

   task automatic flag_error(input string msg);
      errors++;
      $display("Fail %0t: %s", $time, msg);
   endtask

   task automatic flag_timeout(input string msg);
      timeouts++;
      $display("Timed out waiting: %s", msg);
   endtask

   //####################
   // Edge bookkeeping
   //####################

   always @(posedge rx_lclk)
      lclk_edges++;
   always @(posedge rx_lclk_div4)
      div4_edges++;

   always @(posedge rx_active)
   begin
      lclk_at_rise = lclk_edges;
      div4_at_rise = div4_edges;
   end

   // Release lands in the NBA region after the edge count moved
   always @(posedge erx_io_nreset)
      io_release_edges = lclk_edges - lclk_at_rise;
   always @(posedge erx_nreset)
      core_release_edges = div4_edges - div4_at_rise;

   //####################
   // Invariants
   //####################

   // rx_nreset_in low forces all outputs and the core clock low
   assert property (@(posedge sys_clk) disable iff (!checks_on)
      !rx_nreset_in |-> (!rx_active && !erx_nreset && !erx_io_nreset && !rx_lclk_div4))
   else flag_error("outputs not low while rx_nreset_in is low");

   // No domain out of reset while the receiver is down
   assert property (@(posedge rx_clkin) disable iff (!checks_on)
      !rx_active |-> (!erx_nreset && !erx_io_nreset))
   else flag_error("reset output released while rx_active is low");

   // Core clock changes, holds one edge, then changes again
   assert property (@(posedge rx_lclk) disable iff (!checks_on || !rx_active)
      (rx_lclk_div4 != $past(rx_lclk_div4)) |=>
         (rx_lclk_div4 == $past(rx_lclk_div4)) ##1 (rx_lclk_div4 != $past(rx_lclk_div4)))
   else flag_error("rx_lclk_div4 edge not 2 rx_lclk periods after the previous one");

   // Never stuck for more than 2 rx_lclk edges
   assert property (@(posedge rx_lclk) disable iff (!checks_on || !rx_active)
      (rx_lclk_div4 == $past(rx_lclk_div4)) |=> (rx_lclk_div4 != $past(rx_lclk_div4)))
   else flag_error("rx_lclk_div4 held longer than 2 rx_lclk periods");

   // Pass-through clock checked just after every input edge
   always @(rx_clkin)
   begin
      #1;
      if (checks_on)
      begin
         assert (rx_lclk === rx_clkin)
         else flag_error("rx_lclk does not follow rx_clkin");
      end
   end

   //####################
   // Step checks
   //####################

   task automatic check_outputs_low(input string when);
      assert (!rx_active)
      else flag_error({"rx_active high ", when});
      assert (!erx_nreset)
      else flag_error({"erx_nreset high ", when});
      assert (!erx_io_nreset)
      else flag_error({"erx_io_nreset high ", when});
   endtask

   // Sampled on falling edges
   // spent counts the cycles already gone
   task automatic wait_active(input int spent, input string what);
      int n;
      n = spent;
      while (!rx_active && n < UP_CYCLES)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (!rx_active)
         flag_timeout($sformatf("rx_active did not rise within %0d cycles %s", UP_CYCLES, what));
   endtask

   task automatic check_sync_release();
      int n;
      n = 0;
      while (!(erx_io_nreset && erx_nreset) && n < SYNC_CYCLES)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (!(erx_io_nreset && erx_nreset))
         flag_timeout("reset outputs did not release after rx_active rose");
      else
      begin
         assert (io_release_edges >= SYNC_STAGES && io_release_edges <= SYNC_STAGES + 1)
         else flag_error($sformatf("erx_io_nreset released after %0d rx_lclk edges",
                                   io_release_edges));
         assert (core_release_edges >= SYNC_STAGES && core_release_edges <= SYNC_STAGES + 1)
         else flag_error($sformatf("erx_nreset released after %0d rx_lclk_div4 edges",
                                   core_release_edges));
      end
   endtask

   // Soft reset for a number of heartbeats, then bring-up again
   task automatic soft_reset_cycle(input int beats);
      int n;
      n = 0;
      soft_reset = 1'b1;
      while (rx_active && n < DROP_CYCLES)
      begin
         @(negedge sys_clk);
         n++;
      end
      if (rx_active)
         flag_timeout("rx_active did not fall after soft_reset");
      else
         check_outputs_low("after soft_reset");
      while (n < beats * HB_CYCLES)   // Rest of the hold time
      begin
         @(negedge sys_clk);
         n++;
      end
      soft_reset = 1'b0;
      wait_active(0, "after soft_reset low");
      check_sync_release();
   endtask

   //####################
   // Stimulus
   //####################

   initial
   begin
      int beats;
      $timeformat(-9, 0, " ns", 0);
      seed         = 99;
      soft_reset   = 1'b0;
      rx_nreset_in = 1'b1;

      // Reset for 2 cycles with outputs low during and after
      @(negedge sys_clk);
      rx_nreset_in = 1'b0;
      checks_on    = 1'b1;
      repeat (2) @(negedge sys_clk);
      check_outputs_low("during reset");
      assert (!rx_lclk_div4)
      else flag_error("rx_lclk_div4 high during reset");
      rx_nreset_in = 1'b1;
      @(negedge sys_clk);
      check_outputs_low("right after reset");
      assert (!rx_lclk_div4)
      else flag_error("rx_lclk_div4 high right after reset");

      // Bring-up
      wait_active(1, "after reset release");
      check_sync_release();
      repeat (2 * HB_CYCLES) @(negedge sys_clk);   // Let the clock checks run

      // Soft reset with random hold of 1 to 4 heartbeats
      repeat (3)
      begin
         beats = 1 + ($unsigned($random(seed)) % 4);
         soft_reset_cycle(beats);
         repeat (HB_CYCLES) @(negedge sys_clk);
      end

      // Async reset while active
      rx_nreset_in = 1'b0;
      #1;
      check_outputs_low("1 ns into rx_nreset_in low");
      @(negedge sys_clk);
      soft_reset = 1'b1;          // Held from release on
      @(negedge sys_clk);
      rx_nreset_in = 1'b1;

      // Receiver must stay down
      repeat (6 * HB_CYCLES)
      begin
         @(negedge sys_clk);
         assert (!rx_active)
         else flag_error("rx_active high while soft_reset is held");
      end
      soft_reset = 1'b0;
      wait_active(0, "after held soft_reset low");
      check_sync_release();
      repeat (HB_CYCLES) @(negedge sys_clk);

      $display("Done: %0d failed checks, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

//--- files.f
hw/erx_clocks_pkg.sv
hw/erx_pll_if.sv
hw/erx_heartbeat.sv
hw/erx_clk_gen.sv
hw/erx_reset_seq.sv
hw/erx_rsync.sv
hw/erx_clocks.sv
test/erx_clocks_tb.sv

//--- Bender.yml
package:
  name: erx_clocks

sources:
  # Design sources, package and interface first
  - target: any(rtl, test)
    files:
      - hw/erx_clocks_pkg.sv
      - hw/erx_pll_if.sv
      - hw/erx_heartbeat.sv
      - hw/erx_clk_gen.sv
      - hw/erx_reset_seq.sv
      - hw/erx_rsync.sv
      - hw/erx_clocks.sv

  # Testbench
  - target: test
    files:
      - test/erx_clocks_tb.sv
